/* sim/decoding_graph_cases.txt */
// columns in hex: measurements erasures roots odd correction
// roots hold unit 3 in the top two bits down to unit 0 in the bottom two
0 0 e4 0 0
4 0 e4 4 0
4 0 e4 0 0
7 3 c0 0 1
6 3 c0 1 3
c 6 54 0 6
1 5 a0 1 5
8 7 00 0 7
8 0 e4 0 0
f 2 d4 1 2
f 0 e4 0 0
f 0 e4 0 0

/* verilog.f */
+incdir+include
logic/decoding_graph_pkg.sv
logic/syndrome_loader.sv
logic/round_cluster_layer.sv
logic/erasure_peeler.sv
logic/decoding_graph_rsc.sv
sim/decoding_graph_chk.sv
sim/decoding_graph_tb.sv

/* sim/decoding_graph_tb.sv */
`timescale 1ns/10ps

`include "decoding_graph_macros.svh"

module decoding_graph_tb;

    localparam int NUM_CASES  = 12;
    localparam int FIELDS     = 5; // words per case row
    localparam int GROW_LIMIT = 3 * `GRID_WIDTH_X;

    // column of each field inside a case row
    localparam int F_MEAS  = 0;
    localparam int F_ERAS  = 1;
    localparam int F_ROOTS = 2;
    localparam int F_ODD   = 3;
    localparam int F_CORR  = 4;

    logic                       clk;
    logic                       reset;
    decoding_graph_pkg::stage_e global_stage;
    logic [`GRID_WIDTH_X-1:0]   measurements;
    logic [`LINK_COUNT-1:0]     erasure;

    wire [`GRID_WIDTH_U*`GRID_WIDTH_X-1:0][`ADDRESS_WIDTH-1:0] roots;
    wire [`GRID_WIDTH_U*`GRID_WIDTH_X-1:0]                     odd_clusters;
    wire [`GRID_WIDTH_U-1:0]                                   busy;
    wire [`LINK_COUNT-1:0]                                     correction;

    logic [7:0] case_mem [0:NUM_CASES*FIELDS-1];
    int         layer_row [`GRID_WIDTH_U]; // case row held by each layer or -1 when empty

    decoding_graph_rsc u_decoding_graph_rsc (
        .clk            (clk),
        .reset_i        (reset),
        .global_stage_i (global_stage),
        .measurements_i (measurements),
        .erasure_i      (erasure),
        .roots_o        (roots),
        .odd_clusters_o (odd_clusters),
        .busy_o         (busy),
        .correction_o   (correction)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [7:0] case_field(input int row, input int field);
        return case_mem[row*FIELDS+field];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display(">>> FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    // one load edge shifts every round one layer down
    task automatic load_round(input int row);
        logic [7:0] meas_field;
        logic [7:0] eras_field;
        meas_field = case_field(row, F_MEAS);
        eras_field = case_field(row, F_ERAS);
        @(negedge clk);
        measurements = meas_field[`GRID_WIDTH_X-1:0];
        erasure      = eras_field[`LINK_COUNT-1:0];
        global_stage = decoding_graph_pkg::STAGE_LOAD;
        @(posedge clk);
        for (int k = 0; k < `GRID_WIDTH_U-1; k++) begin
            layer_row[k] = layer_row[k+1];
        end
        layer_row[`GRID_WIDTH_U-1] = row;
    endtask

    task automatic grow_phase();
        int                       cycles;
        logic [`GRID_WIDTH_U-1:0] expect_busy;
        expect_busy = '0;
        // any erased link lets unit n+1 pick up the smaller label of unit n
        for (int k = 0; k < `GRID_WIDTH_U; k++) begin
            if (layer_row[k] >= 0 && case_field(layer_row[k], F_ERAS) != 0) begin
                expect_busy[k] = 1'b1;
            end
        end
        cycles = 0;
        @(negedge clk);
        global_stage = decoding_graph_pkg::STAGE_GROW;
        do begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            if (cycles == 1) begin
                check_value("busy_o after the first grow edge", 32'(busy), 32'(expect_busy));
            end
        end while (busy != '0 && cycles < GROW_LIMIT);
        global_stage = decoding_graph_pkg::STAGE_IDLE;
        if (busy != '0) begin
            stop_with_failure($sformatf("layers still busy after %0d grow cycles", GROW_LIMIT));
        end
    endtask

    // compare every layer with the row it should hold
    task automatic check_layers();
        logic [`GRID_WIDTH_X*`ADDRESS_WIDTH-1:0] exp_roots;
        logic [`GRID_WIDTH_X-1:0]                exp_odd;
        logic [`LINK_COUNT-1:0]                  exp_corr;
        logic [7:0]                              odd_field;
        logic [7:0]                              corr_field;
        for (int k = 0; k < `GRID_WIDTH_U; k++) begin
            if (layer_row[k] >= 0) begin
                exp_roots = case_field(layer_row[k], F_ROOTS);
                odd_field = case_field(layer_row[k], F_ODD);
                exp_odd   = odd_field[`GRID_WIDTH_X-1:0];
            end else begin
                for (int i = 0; i < `GRID_WIDTH_X; i++) begin
                    exp_roots[i*`ADDRESS_WIDTH +: `ADDRESS_WIDTH] = `ADDRESS_WIDTH'(i);
                end
                exp_odd = '0; // empty layer
            end
            check_value($sformatf("roots_o of layer %0d", k),
                        32'(roots[k*`GRID_WIDTH_X +: `GRID_WIDTH_X]), 32'(exp_roots));
            check_value($sformatf("odd_clusters_o of layer %0d", k),
                        32'(odd_clusters[k*`GRID_WIDTH_X +: `GRID_WIDTH_X]), 32'(exp_odd));
        end
        check_value("busy_o", 32'(busy), 32'd0);
        exp_corr = '0;
        if (layer_row[0] >= 0) begin
            corr_field = case_field(layer_row[0], F_CORR);
            exp_corr   = corr_field[`LINK_COUNT-1:0];
        end
        check_value("correction_o", 32'(correction), 32'(exp_corr));
    endtask

    initial begin
        reset        = 1'b1;
        global_stage = decoding_graph_pkg::STAGE_IDLE;
        measurements = '0;
        erasure      = '0;
        for (int k = 0; k < `GRID_WIDTH_U; k++) begin
            layer_row[k] = -1;
        end

        $readmemh("sim/decoding_graph_cases.txt", case_mem);
        if ($isunknown(case_mem[0]) || $isunknown(case_mem[NUM_CASES*FIELDS-1])) begin
            stop_with_failure("could not read all rows of sim/decoding_graph_cases.txt");
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_layers(); // nothing loaded yet

        for (int row = 0; row < NUM_CASES; row++) begin
            load_round(row);
            grow_phase();
            check_layers();
        end

        if (u_decoding_graph_rsc.u_decoding_graph_chk.assert_failures == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("%0d assertion failures in the checker",
                     u_decoding_graph_rsc.u_decoding_graph_chk.assert_failures);
            $display(">>> FAIL");
            $fatal(1, "assertions failed");
        end
    end

endmodule

/* sim/decoding_graph_chk.sv */
`timescale 1ns/10ps

`include "decoding_graph_macros.svh"

module decoding_graph_chk (
    input logic                       clk,
    input logic                       reset_i,
    input decoding_graph_pkg::stage_e global_stage_i,
    input logic [`GRID_WIDTH_U-1:0]   busy_i,
    input logic [`LINK_COUNT-1:0]     correction_i,
    input logic [`LINK_COUNT-1:0]     oldest_erased_i // erased links of layer 0
);

    int unsigned assert_failures = 0; // read by the testbench at the end

    // a load or a reset clears every busy flag
    busy_clear_after_load: assert property (
        @(posedge clk) (reset_i || global_stage_i == decoding_graph_pkg::STAGE_LOAD)
            |=> (busy_i == '0)
    ) else begin
        $error("busy_o set in the cycle after a load or a reset");
        assert_failures++;
    end

    // correction is registered, so compare with the oldest round one cycle back
    correction_on_erased_only: assert property (
        @(posedge clk) disable iff (reset_i)
            (correction_i & ~$past(oldest_erased_i)) == '0
    ) else begin
        $error("correction_o set on a link that layer 0 does not mark erased");
        assert_failures++;
    end

    stage_code_defined: assert property (
        @(posedge clk) !$isunknown(global_stage_i) &&
            (global_stage_i inside {decoding_graph_pkg::STAGE_IDLE,
                                    decoding_graph_pkg::STAGE_LOAD,
                                    decoding_graph_pkg::STAGE_GROW})
    ) else begin
        $error("global_stage_i holds an undefined code");
        assert_failures++;
    end

endmodule

bind decoding_graph_rsc decoding_graph_chk u_decoding_graph_chk (
    .clk             (clk),
    .reset_i         (reset_i),
    .global_stage_i  (global_stage_i),
    .busy_i          (busy_o),
    .correction_i    (correction_o),
    .oldest_erased_i (layer_round[0].erased)
);

/* logic/decoding_graph_rsc.sv */
`timescale 1ns/10ps

`include "decoding_graph_macros.svh"

module decoding_graph_rsc (
    input  logic                       clk,
    input  logic                       reset_i,
    input  decoding_graph_pkg::stage_e global_stage_i,
    input  logic [`GRID_WIDTH_X-1:0]   measurements_i,
    input  logic [`LINK_COUNT-1:0]     erasure_i,
    // layer k, unit i sits at index k*GRID_WIDTH_X + i
    output wire  [`GRID_WIDTH_U*`GRID_WIDTH_X-1:0][`ADDRESS_WIDTH-1:0] roots_o,
    output wire  [`GRID_WIDTH_U*`GRID_WIDTH_X-1:0]                     odd_clusters_o,
    output wire  [`GRID_WIDTH_U-1:0]   busy_o,
    output wire  [`LINK_COUNT-1:0]     correction_o
);

    wire decoding_graph_pkg::round_t        new_round;
    wire decoding_graph_pkg::round_t        layer_round  [`GRID_WIDTH_U];
    wire decoding_graph_pkg::layer_status_t layer_status [`GRID_WIDTH_U];

    syndrome_loader u_syndrome_loader (
        .clk            (clk),
        .reset_i        (reset_i),
        .global_stage_i (global_stage_i),
        .measurements_i (measurements_i),
        .erasure_i      (erasure_i),
        .new_round_o    (new_round)
    );

    // layer GRID_WIDTH_U-1 holds the newest round, layer 0 the oldest
    for (genvar k = 0; k < `GRID_WIDTH_U; k++) begin : g_layer
        wire decoding_graph_pkg::round_t upstream;

        if (k == `GRID_WIDTH_U-1) begin : g_newest
            assign upstream = new_round;
        end else begin : g_older
            assign upstream = layer_round[k+1];
        end

        round_cluster_layer u_round_cluster_layer (
            .clk            (clk),
            .reset_i        (reset_i),
            .global_stage_i (global_stage_i),
            .round_i        (upstream),
            .round_o        (layer_round[k]),
            .status_o       (layer_status[k])
        );

        for (genvar i = 0; i < `GRID_WIDTH_X; i++) begin : g_unit
            assign roots_o[k*`GRID_WIDTH_X+i]        = layer_status[k].roots[i];
            assign odd_clusters_o[k*`GRID_WIDTH_X+i] = layer_status[k].odd[i];
        end

        assign busy_o[k] = layer_status[k].busy;
    end

    // corrections come from the round about to leave the graph
    erasure_peeler u_erasure_peeler (
        .clk            (clk),
        .reset_i        (reset_i),
        .oldest_round_i (layer_round[0]),
        .correction_o   (correction_o)
    );

endmodule

/* logic/erasure_peeler.sv */
`timescale 1ns/10ps

`include "decoding_graph_macros.svh"

module erasure_peeler (
    input  logic                       clk,
    input  logic                       reset_i,
    input  decoding_graph_pkg::round_t oldest_round_i,
    output logic [`LINK_COUNT-1:0]     correction_o
);

    logic [`LINK_COUNT-1:0] correction_next;
    logic                   seg_parity; // defect parity since the segment start

    // walk left to right along the chain
    // a link is flipped when the defects to its left in the segment are odd
    always_comb begin
        seg_parity      = 1'b0;
        correction_next = '0;
        for (int n = 0; n < `LINK_COUNT; n++) begin
            seg_parity         = seg_parity ^ oldest_round_i.defects[n];
            correction_next[n] = oldest_round_i.valid & oldest_round_i.erased[n] & seg_parity;
            // unit n+1 starts a new segment when link n is not erased
            if (!oldest_round_i.erased[n]) begin
                seg_parity = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            correction_o <= '0;
        end else begin
            correction_o <= correction_next;
        end
    end

endmodule

/* logic/round_cluster_layer.sv */
`timescale 1ns/10ps

`include "decoding_graph_macros.svh"

module round_cluster_layer (
    input  logic                              clk,
    input  logic                              reset_i,
    input  decoding_graph_pkg::stage_e        global_stage_i,
    input  decoding_graph_pkg::round_t        round_i,
    output decoding_graph_pkg::round_t        round_o,
    output decoding_graph_pkg::layer_status_t status_o
);

    decoding_graph_pkg::round_t round_q;

    // cluster label of every unit
    logic [`GRID_WIDTH_X-1:0][`ADDRESS_WIDTH-1:0] root_q;
    logic                                         busy_q;

    wire [`GRID_WIDTH_X-1:0][`ADDRESS_WIDTH-1:0] own_addr;
    wire [`GRID_WIDTH_X-1:0][`ADDRESS_WIDTH-1:0] root_next;
    wire [`GRID_WIDTH_X-1:0]                     odd;

    for (genvar i = 0; i < `GRID_WIDTH_X; i++) begin : g_unit
        logic [`ADDRESS_WIDTH-1:0] from_left;  // own root unless link i-1 is erased
        logic [`ADDRESS_WIDTH-1:0] from_right; // own root unless link i is erased
        logic                      member_parity;

        assign own_addr[i] = `ADDRESS_WIDTH'(i);

        if (i > 0) begin : g_left
            assign from_left = round_q.erased[i-1] ? root_q[i-1] : root_q[i];
        end else begin : g_no_left
            assign from_left = root_q[i]; // chain end
        end

        if (i < `GRID_WIDTH_X-1) begin : g_right
            assign from_right = round_q.erased[i] ? root_q[i+1] : root_q[i];
        end else begin : g_no_right
            assign from_right = root_q[i];
        end

        // smallest label seen over erased links wins
        assign root_next[i] = (from_left < from_right) ? from_left : from_right;

        // parity of the defects of every unit that carries this unit as root
        always_comb begin
            member_parity = 1'b0;
            for (int j = 0; j < `GRID_WIDTH_X; j++) begin
                if (root_q[j] == own_addr[i]) begin
                    member_parity = member_parity ^ round_q.defects[j];
                end
            end
        end

        // only a root reports its cluster
        assign odd[i] = round_q.valid & (root_q[i] == own_addr[i]) & member_parity;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            round_q <= '0;
            root_q  <= own_addr;
            busy_q  <= 1'b0;
        end else begin
            case (global_stage_i)
                decoding_graph_pkg::STAGE_LOAD: begin
                    round_q <= round_i;  // take the round from the layer above
                    root_q  <= own_addr; // every unit starts as its own cluster
                    busy_q  <= 1'b0;
                end
                decoding_graph_pkg::STAGE_GROW: begin
                    root_q <= root_next;
                    busy_q <= (root_next != root_q); // low once labels stop moving
                end
                default: begin
                    // idle, hold everything
                end
            endcase
        end
    end

    assign round_o = round_q;

    always_comb begin
        status_o.roots = root_q;
        status_o.odd   = odd;
        status_o.busy  = busy_q;
    end

endmodule

/* logic/syndrome_loader.sv */
`timescale 1ns/10ps

`include "decoding_graph_macros.svh"

module syndrome_loader (
    input  logic                       clk,
    input  logic                       reset_i,
    input  decoding_graph_pkg::stage_e global_stage_i,
    input  logic [`GRID_WIDTH_X-1:0]   measurements_i,
    input  logic [`LINK_COUNT-1:0]     erasure_i,
    output decoding_graph_pkg::round_t new_round_o
);

    // measurements of the round loaded last
    logic [`GRID_WIDTH_X-1:0] prev_measurements;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_measurements <= '0;
        end else if (global_stage_i == decoding_graph_pkg::STAGE_LOAD) begin
            prev_measurements <= measurements_i;
        end
    end

    // a detection event is a stabilizer that changed since the last round
    always_comb begin
        new_round_o.valid   = 1'b1;
        new_round_o.defects = measurements_i ^ prev_measurements;
        new_round_o.erased  = erasure_i; // erasures of this round only
    end

endmodule

/* logic/decoding_graph_pkg.sv */
`include "decoding_graph_macros.svh"

package decoding_graph_pkg;

    // stage driven by the controller, held as a plain level
    typedef enum logic [`STAGE_WIDTH-1:0] {
        STAGE_IDLE = 0,
        STAGE_LOAD = 1, // shift all rounds down one layer
        STAGE_GROW = 2  // move cluster labels one link
    } stage_e;

    // one measurement round
    typedef struct packed {
        logic                     valid;   // layer holds real data
        logic [`GRID_WIDTH_X-1:0] defects; // detection events
        logic [`LINK_COUNT-1:0]   erased;  // erased links of the round
    } round_t;

    // what one layer reports to the top
    typedef struct packed {
        logic [`GRID_WIDTH_X-1:0][`ADDRESS_WIDTH-1:0] roots;
        logic [`GRID_WIDTH_X-1:0]                     odd;
        logic                                         busy;
    } layer_status_t;

endpackage

/* include/decoding_graph_macros.svh */
`ifndef DECODING_GRAPH_MACROS_SVH
`define DECODING_GRAPH_MACROS_SVH

// one column of the rotated surface code lattice per round

// units in one round
`define GRID_WIDTH_X 4

// rounds held in the graph, one per layer
`define GRID_WIDTH_U 3

// internal links of the chain, link n joins unit n and unit n+1
`define LINK_COUNT (`GRID_WIDTH_X-1)

// unit address inside a round
`define ADDRESS_WIDTH 2

// global stage code
`define STAGE_WIDTH 2

`endif
